//--- gem_frame_align.sv
module gem_frame_align (
  input  logic                               clock,
  input  logic                               gtx_rx_reset,
  input  logic [gem_link_pkg::WORD_BITS-1:0] rx_word,
  input  logic                               rx_k,
  input  logic                               align_en,
  input  logic                               clear_sync,
  frame_if.source                            fr,
  output logic                               fc_seen
);
  import gem_link_pkg::*;

  align_state_t                     state;
  logic [WORD_POS_BITS-1:0]         pos;       // Position of the incoming word
  logic                             err_pend;  // Comma fault seen in frame under way
  logic [FRAME_BITS-WORD_BITS-1:0]  part;      // Last three words
  logic [FRAME_BITS-1:0]            full;
  logic                             relock;
  logic                             misplaced;
  logic                             missing;
  logic                             last_word;

  assign full      = {part, rx_word};
  assign relock    = (state != LOCKED) && rx_k;
  assign misplaced = (state == LOCKED) && rx_k && (pos != '0);
  assign missing   = (state == LOCKED) && !rx_k && (pos == '0);
  assign last_word = (state == LOCKED) && !rx_k
                     && (pos == WORD_POS_BITS'(WORDS_PER_FRAME - 1));

  // Word shifter, word 0 ends up in the high bits
  always_ff @(posedge clock) begin
    part <= full[FRAME_BITS-WORD_BITS-1:0];
    if (last_word) fr.frame <= full;
  end

  always_ff @(posedge clock or posedge gtx_rx_reset) begin
    if (gtx_rx_reset) begin
      state           <= HUNT;
      pos             <= '0;
      err_pend        <= 1'b0;
      fr.frame_strobe <= 1'b0;
      fr.start        <= 1'b0;
      fr.fc           <= 1'b0;
      fr.frame_err    <= 1'b0;
      fc_seen         <= 1'b0;
    end else begin
      fr.frame_strobe <= 1'b0;
      if (clear_sync)                      fc_seen <= 1'b0;
      else if (fr.frame_strobe && fr.fc)   fc_seen <= 1'b1;  // Sticky latency flag

      if (clear_sync || !align_en) begin
        state    <= HUNT;
        pos      <= '0;
        err_pend <= 1'b0;
        fr.start <= 1'b0;
      end else if (relock || misplaced) begin
        state    <= LOCKED;  // This comma is word 0
        pos      <= WORD_POS_BITS'(1);
        fr.start <= 1'b1;
        if (misplaced) err_pend <= 1'b1;
      end else if (missing) begin
        state    <= LOST;    // Drop the frame, wait for a comma
        err_pend <= 1'b1;
      end else if (state == LOCKED) begin
        pos <= pos + 1'b1;   // Wraps to 0 after the last word
        if (last_word) begin
          fr.frame_strobe <= 1'b1;
          fr.frame_err    <= err_pend;
          fr.fc           <= (full == FC_FRAME);
          err_pend        <= 1'b0;
        end
      end
    end
  end

endmodule

//--- gem_frame_delay.sv
module gem_frame_delay (
  input  logic                                clock,
  input  logic                                gtx_rx_reset,
  frame_if.sink                               fr,
  input  logic [gem_reg_pkg::DELAY_BITS-1:0]  delay,
  input  logic                                link_good,
  input  logic                                link_bad,
  output logic [gem_link_pkg::FRAME_BITS-1:0] rx_data,
  output logic                                rx_frame_strobe
);
  import gem_link_pkg::*;
  import gem_reg_pkg::*;

  logic [FRAME_BITS-1:0] line [DELAY_DEPTH];  // line[0] holds the newest frame
  logic                  ignore_link;

  // Keep a bad link out of the trigger path
  assign ignore_link = !link_good || link_bad;

  always_ff @(posedge clock or posedge gtx_rx_reset) begin
    if (gtx_rx_reset) begin
      for (int i = 0; i < DELAY_DEPTH; i++) line[i] <= '0;
      rx_data         <= '0;
      rx_frame_strobe <= 1'b0;
    end else begin
      rx_frame_strobe <= fr.frame_strobe;
      if (fr.frame_strobe) begin
        rx_data <= line[delay];  // Read before shift, so delay 0 gives one frame
        line[0] <= ignore_link ? '0 : fr.frame;
        for (int i = 1; i < DELAY_DEPTH; i++) line[i] <= line[i-1];
      end
    end
  end

endmodule

//--- gem_link_monitor.sv
module gem_link_monitor (
  input  logic                                   clock,
  input  logic                                   gtx_rx_reset,
  input  logic                                   ttc_resync,
  frame_if.sink                                  fr,
  output logic                                   link_good,
  output logic                                   link_bad,
  output logic                                   link_had_err,
  output logic [gem_link_pkg::LINK_CNT_BITS-1:0] link_count
);
  import gem_link_pkg::*;

  logic [GOOD_CNT_BITS-1:0] clean_cnt;  // Clean frames since the last error

  assign link_bad = (link_count >= LINK_CNT_BITS'(BAD_ERRORS));

  always_ff @(posedge clock or posedge gtx_rx_reset) begin
    if (gtx_rx_reset) begin
      link_count   <= '0;
      link_had_err <= 1'b0;
      link_good    <= 1'b0;
      clean_cnt    <= '0;
    end else if (ttc_resync) begin
      link_count   <= '0;   // Resync starts a fresh health window
      link_had_err <= 1'b0;
      link_good    <= 1'b0;
      clean_cnt    <= '0;
    end else if (fr.frame_strobe) begin
      if (fr.frame_err) begin
        if (!(&link_count)) link_count <= link_count + 1'b1;
        link_had_err <= 1'b1;
        link_good    <= 1'b0;
        clean_cnt    <= '0;
      end else begin
        if (clean_cnt != GOOD_CNT_BITS'(GOOD_FRAMES)) clean_cnt <= clean_cnt + 1'b1;
        if (clean_cnt >= GOOD_CNT_BITS'(GOOD_FRAMES - 1)) link_good <= 1'b1;
      end
    end
  end

endmodule

//--- gem_link_pkg.sv
package gem_link_pkg;

  // Received word stream
  localparam int WORD_BITS       = 14;
  localparam int WORDS_PER_FRAME = 4;
  localparam int FRAME_BITS      = WORD_BITS * WORDS_PER_FRAME;  // 56
  localparam int WORD_POS_BITS   = $clog2(WORDS_PER_FRAME);

  // Latency marker, the FC code repeated in every word
  localparam logic [FRAME_BITS-1:0] FC_FRAME = {WORDS_PER_FRAME{14'h00FC}};

  // --------------------
  // Link health monitor
  localparam int GOOD_FRAMES   = 16;                          // Clean frames in a row for good
  localparam int GOOD_CNT_BITS = $clog2(GOOD_FRAMES + 1);
  localparam int BAD_ERRORS    = 8;                           // Error count that marks a bad link
  localparam int LINK_CNT_BITS = 8;

  // Frame builder lock state
  typedef enum logic [1:0] {
    HUNT,    // Waiting for the first comma
    LOCKED,  // Counting word positions
    LOST     // Comma missing, waiting to relock
  } align_state_t;

endpackage

//--- gem_optical_rx.sv
module gem_optical_rx (
  input  logic                                  clock,
  input  logic                                  gtx_rx_reset,
  input  logic                                  clocks_rdy,
  input  logic                                  ttc_resync,  // Clears the link monitor
  input  logic [gem_link_pkg::WORD_BITS-1:0]    rx_word,
  input  logic                                  rx_k,        // Comma on word 0
  input  logic                                  wb_cyc,
  input  logic                                  wb_stb,
  input  logic                                  wb_we,
  input  logic [1:0]                            wb_adr,
  input  logic [gem_reg_pkg::WB_DATA_BITS-1:0]  wb_dat_w,
  output logic [gem_reg_pkg::WB_DATA_BITS-1:0]  wb_dat_r,
  output logic                                  wb_ack,
  output logic [gem_link_pkg::FRAME_BITS-1:0]   rx_data,
  output logic                                  rx_frame_strobe,
  output logic                                  rx_fc,
  output logic                                  rx_rst_done,
  output logic                                  rx_sync_done,
  output logic                                  link_good,
  output logic                                  link_bad,
  output logic                                  link_had_err
);
  import gem_reg_pkg::*;

  frame_if fr ();
  cfg_if   cfg ();

  gem_rx_ctrl u_ctrl (
    .clock(clock), .gtx_rx_reset(gtx_rx_reset), .clocks_rdy(clocks_rdy),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
    .wb_adr(reg_addr_t'(wb_adr)),
    .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
    .rst_done(rx_rst_done), .sync_done(rx_sync_done),
    .start(fr.start), .cfg(cfg)
  );

  gem_frame_align u_align (
    .clock(clock), .gtx_rx_reset(gtx_rx_reset),
    .rx_word(rx_word), .rx_k(rx_k),
    .align_en(cfg.align_en), .clear_sync(cfg.clear_sync),
    .fr(fr), .fc_seen(cfg.fc_seen)
  );

  // PRBS checking only runs on a synced link
  gem_prbs_check u_prbs (
    .clock(clock), .gtx_rx_reset(gtx_rx_reset), .fr(fr),
    .prbs_en(cfg.prbs_en & cfg.sync_done), .clear_prbs(cfg.clear_prbs),
    .prbs_err(cfg.prbs_err), .prbs_count(cfg.prbs_count)
  );

  gem_link_monitor u_monitor (
    .clock(clock), .gtx_rx_reset(gtx_rx_reset), .ttc_resync(ttc_resync), .fr(fr),
    .link_good(cfg.link_good), .link_bad(cfg.link_bad),
    .link_had_err(cfg.link_had_err), .link_count(cfg.link_count)
  );

  gem_frame_delay u_delay (
    .clock(clock), .gtx_rx_reset(gtx_rx_reset), .fr(fr), .delay(cfg.delay),
    .link_good(cfg.link_good), .link_bad(cfg.link_bad),
    .rx_data(rx_data), .rx_frame_strobe(rx_frame_strobe)
  );

  assign rx_fc        = cfg.fc_seen;
  assign link_good    = cfg.link_good;
  assign link_bad     = cfg.link_bad;
  assign link_had_err = cfg.link_had_err;

endmodule

//--- gem_optical_rx_sva.sv
module gem_optical_rx_sva (
  input logic clock,
  input logic gtx_rx_reset,
  input logic wb_ack,
  input logic rx_rst_done,
  input logic rx_sync_done,
  input logic rx_frame_strobe
);

  int fail_count;  // Failed assertions so far

  // --------------------
  // Wishbone ack is a one cycle pulse
  ack_single: assert property (@(posedge clock) disable iff (gtx_rx_reset)
    wb_ack |=> !wb_ack)
    else begin
      $error("wb_ack held high for two cycles");
      fail_count++;
    end

  // Sync only after the link reset window
  sync_after_rst: assert property (@(posedge clock) disable iff (gtx_rx_reset)
    rx_sync_done |-> rx_rst_done)
    else begin
      $error("rx_sync_done without rx_rst_done");
      fail_count++;
    end

  // One frame per four words at most
  strobe_spacing: assert property (@(posedge clock) disable iff (gtx_rx_reset)
    rx_frame_strobe |=> !rx_frame_strobe ##1 !rx_frame_strobe ##1 !rx_frame_strobe)
    else begin
      $error("rx_frame_strobe closer than four cycles");
      fail_count++;
    end

endmodule

bind gem_optical_rx gem_optical_rx_sva u_sva (.*);

//--- gem_optical_rx_tb.sv
module gem_optical_rx_tb;
  import gem_link_pkg::*;
  import gem_reg_pkg::*;

  // Frame budget per test for sync, delay, FC, PRBS and link errors
  localparam int RUN_FRAMES = 10 + 60 + 10 + 30 + 60;
  localparam int MAX_CYCLES = RUN_FRAMES * WORDS_PER_FRAME + 400;

  logic                    clock;
  logic                    gtx_rx_reset;
  logic                    clocks_rdy;
  logic                    ttc_resync;
  logic [WORD_BITS-1:0]    rx_word;
  logic                    rx_k;
  logic                    wb_cyc;
  logic                    wb_stb;
  logic                    wb_we;
  logic [1:0]              wb_adr;
  logic [WB_DATA_BITS-1:0] wb_dat_w;
  logic [WB_DATA_BITS-1:0] wb_dat_r;
  logic                    wb_ack;
  logic [FRAME_BITS-1:0]   rx_data;
  logic                    rx_frame_strobe;
  logic                    rx_fc;
  logic                    rx_rst_done;
  logic                    rx_sync_done;
  logic                    link_good;
  logic                    link_bad;
  logic                    link_had_err;

  int                    errors;
  int                    checks;
  int                    cycles;
  string                 test_name;
  logic [FRAME_BITS-1:0] tx_q[$];      // Frames waiting for the word stream
  bit                    tx_bad_q[$];  // Comma left off word 0
  logic [FRAME_BITS-1:0] exp_q[$];     // Frames the aligner will deliver
  bit                    exp_err_q[$];
  logic [FRAME_BITS-1:0] chain;        // Clean PRBS chain position
  bit                    stream_on;
  bit                    data_check;
  logic [DELAY_BITS-1:0] cur_delay;

  gem_optical_rx UUT (.*);

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  // --------------------
  // Reference model
  function automatic logic [FRAME_BITS-1:0] prbs_next(input logic [FRAME_BITS-1:0] f);
    return {f[FRAME_BITS-2:0], f[55] ^ f[54] ^ f[34] ^ f[33]};
  endfunction

  task automatic check_equal(input string what, input logic [63:0] exp_v,
                             input logic [63:0] act_v);
    checks++;
    assert (exp_v === act_v) else begin
      errors++;
      $display("mismatch %s %s: expected %h actual %h", test_name, what, exp_v, act_v);
    end
  endtask

  task automatic finish_run;
    int sva_fails;
    sva_fails = UUT.u_sva.fail_count;
    $display("checks %0d, errors %0d, assertion failures %0d", checks, errors, sva_fails);
    if (errors == 0 && sva_fails == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  endtask

  // --------------------
  // Wishbone and stream tasks
  task automatic wb_access(input bit we, input logic [1:0] adr,
                           input logic [15:0] wdat, output logic [15:0] rdat);
    int waited;
    waited   = 0;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdat;
    do begin
      @(posedge clock);
      #10;
      waited++;
    end while (!wb_ack && waited < 8);
    assert (wb_ack) else begin
      errors++;
      $display("Wishbone slave gave no ack at address %0d", adr);
    end
    rdat   = wb_dat_r;  // Valid while ack is high
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
  endtask

  task automatic wb_write(input logic [1:0] adr, input logic [15:0] dat);
    logic [15:0] unused;
    wb_access(1'b1, adr, dat, unused);
  endtask

  task automatic wb_read(input logic [1:0] adr, output logic [15:0] dat);
    wb_access(1'b0, adr, 16'h0000, dat);
  endtask

  task automatic send_frame(input logic [FRAME_BITS-1:0] f, input bit comma_err);
    tx_q.push_back(f);
    tx_bad_q.push_back(comma_err);
  endtask

  task automatic wait_strobes(input int n);
    int seen;
    seen = 0;
    while (seen < n) begin
      @(posedge clock);
      #10;
      if (rx_frame_strobe) seen++;
    end
  endtask

  task automatic drain_frames(input int n);
    while (tx_q.size() != 0) begin
      @(posedge clock);
      #10;
    end
    wait_strobes(n);  // Let the last frames reach rx_data
  endtask

  // Word stream that never stops once started
  initial begin : stream
    logic [FRAME_BITS-1:0] f;
    bit                    bad;
    bit                    pend_err;
    pend_err = 1'b0;
    wait (stream_on);
    forever begin
      if (tx_q.size() != 0) begin
        f   = tx_q.pop_front();
        bad = tx_bad_q.pop_front();
      end else begin
        chain = prbs_next(chain);  // Idle frames continue the chain
        f     = chain;
        bad   = 1'b0;
      end
      for (int w = 0; w < WORDS_PER_FRAME; w++) begin
        rx_word = f[FRAME_BITS-1-w*WORD_BITS -: WORD_BITS];  // Word 0 first
        rx_k    = (w == 0) && !bad;
        if (w == WORDS_PER_FRAME - 1) begin
          if (bad) begin
            pend_err = 1'b1;  // Dropped frame passes its error to the next one
          end else begin
            exp_q.push_back(f);
            exp_err_q.push_back(pend_err);
            pend_err = 1'b0;
          end
        end
        @(posedge clock);
        #10;
      end
    end
  end

  // Compares delay line and link monitor against the model
  initial begin : compare
    logic [FRAME_BITS-1:0] dly_line [DELAY_DEPTH];
    logic [FRAME_BITS-1:0] f;
    logic [FRAME_BITS-1:0] exp_data;
    bit                    err;
    bit                    got;
    bit                    resync_seen;
    bit                    good;
    bit                    had;
    int                    link_cnt;
    int                    clean;
    foreach (dly_line[i]) dly_line[i] = '0;
    resync_seen = 1'b0;
    good        = 1'b0;
    had         = 1'b0;
    link_cnt    = 0;
    clean       = 0;
    forever begin
      @(negedge clock);
      got = 1'b0;
      if (rx_frame_strobe) begin
        assert (exp_q.size() != 0) else begin
          errors++;
          $display("frame strobe seen with no frame sent");
        end
        if (exp_q.size() != 0) begin
          f        = exp_q.pop_front();
          err      = exp_err_q.pop_front();
          got      = 1'b1;
          exp_data = dly_line[cur_delay];
          for (int i = DELAY_DEPTH - 1; i > 0; i--) dly_line[i] = dly_line[i-1];
          dly_line[0] = (good && link_cnt < BAD_ERRORS) ? f : '0;  // Blank bad link
          if (data_check) check_equal("rx_data", exp_data, rx_data);
        end
      end
      if (resync_seen) begin
        link_cnt = 0;
        clean    = 0;
        good     = 1'b0;
        had      = 1'b0;
      end else if (got && err) begin
        if (link_cnt < 255) link_cnt++;
        had   = 1'b1;
        good  = 1'b0;
        clean = 0;
      end else if (got) begin
        if (clean < GOOD_FRAMES) clean++;
        if (clean >= GOOD_FRAMES) good = 1'b1;
      end
      check_equal("link_good", good, link_good);
      check_equal("link_bad", link_cnt >= BAD_ERRORS, link_bad);
      check_equal("link_had_err", had, link_had_err);
      resync_seen = ttc_resync;  // Takes effect on the coming edge
    end
  end

  initial begin : watchdog
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clock);
      cycles++;
    end
    errors++;
    $display("timeout, run did not finish within %0d cycles", MAX_CYCLES);
    finish_run();
  end

  initial begin : main
    logic [15:0]           rd;
    logic [FRAME_BITS-1:0] c;
    logic [DELAY_BITS-1:0] dly;
    void'($urandom(32'h5927));
    errors       = 0;
    checks       = 0;
    test_name    = "reset";
    gtx_rx_reset = 1'b1;
    clocks_rdy   = 1'b0;
    ttc_resync   = 1'b0;
    rx_word      = '0;
    rx_k         = 1'b0;
    wb_cyc       = 1'b0;
    wb_stb       = 1'b0;
    wb_we        = 1'b0;
    wb_adr       = '0;
    wb_dat_w     = '0;
    stream_on    = 1'b0;
    data_check   = 1'b0;
    cur_delay    = '0;
    chain        = FRAME_BITS'({$urandom, $urandom}) | 1;  // Nonzero seed
    repeat (4) @(posedge clock);
    #10;
    gtx_rx_reset = 1'b0;

    // --------------------
    // Reset and sync
    wb_read(REG_STATUS, rd);
    check_equal("status after reset", 0, rd);
    clocks_rdy = 1'b1;
    while (!rx_rst_done) begin
      @(posedge clock);
      #10;
    end
    check_equal("sync before rst_done", 0, rx_sync_done);
    stream_on = 1'b1;
    while (!rx_sync_done) begin
      @(posedge clock);
      #10;
    end
    wb_read(REG_STATUS, rd);
    check_equal("status sync bits", 3'b111, rd[2:0]);

    // Data through a random delay
    test_name = "delay";
    dly       = $urandom % DELAY_DEPTH;
    wb_write(REG_CONTROL, WB_DATA_BITS'({dly, 4'h0}));
    @(posedge clock);
    #10;
    cur_delay  = dly;
    data_check = 1'b1;
    for (int i = 0; i < 40; i++) begin
      chain = FRAME_BITS'({$urandom, $urandom});
      send_frame(chain, 1'b0);
    end
    drain_frames(DELAY_DEPTH + 2);
    check_equal("link_good", 1, link_good);

    // Latency marker
    test_name = "fc";
    chain     = FC_FRAME;
    send_frame(chain, 1'b0);
    drain_frames(3);
    wb_read(REG_STATUS, rd);
    check_equal("status fc_seen", 1, rd[7]);
    check_equal("rx_fc", 1, rx_fc);

    // --------------------
    // PRBS chain with three single bit hits
    test_name = "prbs";
    wb_write(REG_CONTROL, WB_DATA_BITS'({cur_delay, 4'h1}));
    wb_write(REG_COMMAND, 16'h0002);
    for (int i = 0; i < 20; i++) begin
      chain = prbs_next(chain);
      c     = chain;
      if (i == 3 || i == 8 || i == 13) c = c ^ (FRAME_BITS'(1) << ($urandom % FRAME_BITS));
      send_frame(c, 1'b0);
    end
    drain_frames(3);
    wb_read(REG_ERR_COUNT, rd);
    check_equal("prbs count", 6, rd);
    wb_write(REG_COMMAND, 16'h0002);
    wb_read(REG_ERR_COUNT, rd);
    check_equal("prbs count cleared", 0, rd);
    wb_write(REG_CONTROL, WB_DATA_BITS'({cur_delay, 4'h0}));

    // Comma errors until the link goes bad
    test_name = "link errors";
    for (int i = 0; i < BAD_ERRORS; i++) begin
      chain = prbs_next(chain);
      send_frame(chain, 1'b1);
      chain = prbs_next(chain);
      send_frame(chain, 1'b0);
    end
    drain_frames(3);
    check_equal("link_bad", 1, link_bad);
    check_equal("link_had_err", 1, link_had_err);
    wb_read(REG_ERR_COUNT, rd);
    check_equal("link count", BAD_ERRORS, rd);
    wait_strobes(DELAY_DEPTH + 1);
    check_equal("rx_data blanked", 0, rx_data);
    ttc_resync = 1'b1;
    @(posedge clock);
    #10;
    ttc_resync = 1'b0;
    wait_strobes(GOOD_FRAMES + 2);
    check_equal("link_good after resync", 1, link_good);
    check_equal("link_had_err after resync", 0, link_had_err);
    finish_run();
  end

endmodule

//--- gem_prbs_check.sv
module gem_prbs_check (
  input  logic                                   clock,
  input  logic                                   gtx_rx_reset,
  frame_if.sink                                  fr,
  input  logic                                   prbs_en,
  input  logic                                   clear_prbs,
  output logic                                   prbs_err,
  output logic [gem_reg_pkg::ERR_COUNT_BITS-1:0] prbs_count
);
  import gem_link_pkg::*;
  import gem_reg_pkg::*;

  logic [FRAME_BITS-1:0] prev;      // Last received frame
  logic [FRAME_BITS-1:0] predict;
  logic                  have_prev;
  logic                  mismatch;

  // Self-synchronizing, next frame comes from the previous received one
  assign predict  = {prev[FRAME_BITS-2:0], prev[55] ^ prev[54] ^ prev[34] ^ prev[33]};
  assign mismatch = have_prev && (fr.frame != predict);

  always_ff @(posedge clock) begin
    if (fr.frame_strobe) prev <= fr.frame;
  end

  always_ff @(posedge clock or posedge gtx_rx_reset) begin
    if (gtx_rx_reset) begin
      have_prev  <= 1'b0;
      prbs_err   <= 1'b0;
      prbs_count <= '0;
    end else if (clear_prbs) begin
      prbs_err   <= 1'b0;
      prbs_count <= '0;
    end else if (!prbs_en) begin
      have_prev <= 1'b0;  // Idle, restart seeding on enable
      prbs_err  <= 1'b0;
    end else if (fr.frame_strobe) begin
      have_prev <= 1'b1;
      prbs_err  <= mismatch;
      if (mismatch && !(&prbs_count)) prbs_count <= prbs_count + 1'b1;  // Saturate
    end
  end

endmodule

//--- gem_reg_pkg.sv
package gem_reg_pkg;

  localparam int WB_DATA_BITS = 16;

  // Register map, 2-bit word address
  typedef enum logic [1:0] {
    REG_CONTROL   = 2'd0,  // R/W
    REG_STATUS    = 2'd1,  // RO
    REG_ERR_COUNT = 2'd2,  // RO
    REG_COMMAND   = 2'd3   // WO, self clearing
  } reg_addr_t;

  // --------------------
  // Control and command fields
  localparam int PRBS_EN_BIT  = 0;
  localparam int DELAY_LSB    = 4;   // Delay field is bits 7:4
  localparam int DELAY_BITS   = 4;
  localparam int DELAY_DEPTH  = 2 ** DELAY_BITS;
  localparam int CLR_SYNC_BIT = 0;
  localparam int CLR_PRBS_BIT = 1;

  localparam int ERR_COUNT_BITS = 16;

  // Link reset and sync sequence
  localparam int RST_CYCLES   = 8;
  localparam int RST_CNT_BITS = $clog2(RST_CYCLES);

  typedef enum logic [1:0] {
    WAIT_CLOCKS,  // Hold until clocks_rdy
    LINK_RESET,   // Fixed reset window
    LINK_SYNC,    // Aligner hunting for a comma
    READY
  } sync_state_t;

endpackage

//--- gem_rx_ctrl.sv
module gem_rx_ctrl (
  input  logic                                  clock,
  input  logic                                  gtx_rx_reset,
  input  logic                                  clocks_rdy,
  input  logic                                  wb_cyc,
  input  logic                                  wb_stb,
  input  logic                                  wb_we,
  input  gem_reg_pkg::reg_addr_t                wb_adr,
  input  logic [gem_reg_pkg::WB_DATA_BITS-1:0]  wb_dat_w,
  output logic [gem_reg_pkg::WB_DATA_BITS-1:0]  wb_dat_r,
  output logic                                  wb_ack,
  output logic                                  rst_done,
  output logic                                  sync_done,
  input  logic                                  start,
  cfg_if.ctrl                                   cfg
);
  import gem_reg_pkg::*;

  sync_state_t             state;
  logic [RST_CNT_BITS-1:0] rst_cnt;   // Cycles spent in LINK_RESET
  logic                    wb_hit;    // Cycle is being acked on this edge
  logic                    wr_hit;
  logic [WB_DATA_BITS-1:0] rd_mux;

  assign wb_hit = wb_cyc && wb_stb && !wb_ack;  // No back to back ack
  assign wr_hit = wb_hit && wb_we;

  // --------------------
  // Reset and sync sequence
  always_ff @(posedge clock or posedge gtx_rx_reset) begin
    if (gtx_rx_reset) begin
      state   <= WAIT_CLOCKS;
      rst_cnt <= '0;
    end else if (!clocks_rdy || cfg.clear_sync) begin
      state   <= WAIT_CLOCKS;  // Lost clocks or software resync
    end else begin
      case (state)
        WAIT_CLOCKS: begin
          state   <= LINK_RESET;
          rst_cnt <= '0;
        end
        LINK_RESET: begin
          rst_cnt <= rst_cnt + 1'b1;
          if (rst_cnt == RST_CNT_BITS'(RST_CYCLES - 1)) state <= LINK_SYNC;
        end
        LINK_SYNC: if (start) state <= READY;  // Aligner found its comma
        default:   state <= READY;
      endcase
    end
  end

  assign rst_done      = (state == LINK_SYNC) || (state == READY);
  assign sync_done     = (state == READY);
  assign cfg.align_en  = rst_done;   // Aligner may lock once reset is done
  assign cfg.sync_done = sync_done;

  // --------------------
  // Read mux
  always_comb begin
    rd_mux = '0;
    case (wb_adr)
      REG_CONTROL: begin
        rd_mux[PRBS_EN_BIT]             = cfg.prbs_en;
        rd_mux[DELAY_LSB +: DELAY_BITS] = cfg.delay;
      end
      REG_STATUS: rd_mux = WB_DATA_BITS'({cfg.fc_seen, cfg.prbs_err, cfg.link_had_err,
                                          cfg.link_bad, cfg.link_good, start,
                                          sync_done, rst_done});
      REG_ERR_COUNT: rd_mux = cfg.prbs_en ? cfg.prbs_count
                                          : ERR_COUNT_BITS'(cfg.link_count);
      default: rd_mux = '0;  // Command register reads back zero
    endcase
  end

  // Wishbone slave, writes land on the ack edge
  always_ff @(posedge clock or posedge gtx_rx_reset) begin
    if (gtx_rx_reset) begin
      wb_ack         <= 1'b0;
      wb_dat_r       <= '0;
      cfg.prbs_en    <= 1'b0;
      cfg.delay      <= '0;
      cfg.clear_prbs <= 1'b0;
      cfg.clear_sync <= 1'b0;
    end else begin
      wb_ack <= wb_hit;
      if (wb_hit) wb_dat_r <= rd_mux;
      cfg.clear_sync <= wr_hit && (wb_adr == REG_COMMAND) && wb_dat_w[CLR_SYNC_BIT];
      cfg.clear_prbs <= wr_hit && (wb_adr == REG_COMMAND) && wb_dat_w[CLR_PRBS_BIT];
      if (wr_hit && (wb_adr == REG_CONTROL)) begin
        cfg.prbs_en <= wb_dat_w[PRBS_EN_BIT];
        cfg.delay   <= wb_dat_w[DELAY_LSB +: DELAY_BITS];
      end
    end
  end

endmodule

//--- gem_rx_if.sv
interface frame_if;
  import gem_link_pkg::*;

  logic [FRAME_BITS-1:0] frame;  // Word 0 in the high bits
  logic                  frame_strobe;  // One cycle per frame
  logic                  start;  // Aligner has locked
  logic                  fc;     // Frame equals FC_FRAME
  logic                  frame_err;  // Comma misplaced or missing

  modport source (output frame, frame_strobe, start, fc, frame_err);
  modport sink   (input  frame, frame_strobe, start, fc, frame_err);
endinterface

interface cfg_if;
  import gem_link_pkg::*;
  import gem_reg_pkg::*;

  // From the control block
  logic                  prbs_en;
  logic [DELAY_BITS-1:0] delay;
  logic                  clear_prbs;  // One cycle pulse
  logic                  clear_sync;  // One cycle pulse
  logic                  sync_done;
  logic                  align_en;

  // Back from the datapath
  logic                      prbs_err;
  logic [ERR_COUNT_BITS-1:0] prbs_count;
  logic                      link_good;
  logic                      link_bad;
  logic                      link_had_err;
  logic [LINK_CNT_BITS-1:0]  link_count;
  logic                      fc_seen;

  modport ctrl (
    output prbs_en, delay, clear_prbs, clear_sync, sync_done, align_en,
    input  prbs_err, prbs_count, link_good, link_bad, link_had_err, link_count, fc_seen
  );
  modport datapath (
    input  prbs_en, delay, clear_prbs, clear_sync, sync_done, align_en,
    output prbs_err, prbs_count, link_good, link_bad, link_had_err, link_count, fc_seen
  );
endinterface

//--- sources.f
gem_link_pkg.sv
gem_reg_pkg.sv
gem_rx_if.sv
gem_rx_ctrl.sv
gem_frame_align.sv
gem_prbs_check.sv
gem_link_monitor.sv
gem_frame_delay.sv
gem_optical_rx.sv
gem_optical_rx_sva.sv
gem_optical_rx_tb.sv
